// File: design/ulpb_pkg.sv
package ulpb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int MSG_WIDTH = ADDR_WIDTH + DATA_WIDTH;	// bits shifted per message.
	localparam int COUNT_WIDTH = 16;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// messages and status
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// address goes out first, so it sits in the upper bits.
	typedef struct packed {
		addr_t addr;
		data_t data;
	} msg_t;

	typedef struct packed {
		logic bus_idle;	// phase machine sits in the idle phase.
		logic driving;	// ring output comes from the node itself.
	} node_status_t;

	// every node steps through these in lockstep.
	typedef enum logic [2:0] {
		bus_idle,
		arbi_resolved,
		drive1,
		latch1,
		drive2,
		latch2,
		bus_reset
	} phase_t;

	typedef enum logic [1:0] {
		idle,
		tx,
		rx,
		fwd
	} node_mode_t;

endpackage

// File: design/ulpb_node.sv
`timescale 1ns/10ps

module ulpb_node #(
	parameter ulpb_pkg::addr_t NODE_ADDR = '0,
	parameter int RESET_CNT = 2
) (
	input  logic CLK,
	input  logic RESET,
	input  logic din,
	output logic dout,
	input  ulpb_pkg::msg_t msg_tx,
	input  logic req_tx,
	output logic ack_tx,
	output ulpb_pkg::msg_t msg_rx,
	output logic req_rx,
	input  logic ack_rx,
	output logic ack_received,
	output ulpb_pkg::node_status_t status
);

	localparam int MSG_W = ulpb_pkg::MSG_WIDTH;
	localparam int SLOT_W = $clog2(MSG_W + 2);
	localparam int RST_W = (RESET_CNT > 1) ? $clog2(RESET_CNT) : 1;

	// slot numbers within a message: payload bits, then the end slot, then the ack slot.
	localparam logic [SLOT_W-1:0] ADDR_SLOTS = SLOT_W'(ulpb_pkg::ADDR_WIDTH);
	localparam logic [SLOT_W-1:0] LAST_BIT = SLOT_W'(MSG_W - 1);
	localparam logic [SLOT_W-1:0] END_SLOT = SLOT_W'(MSG_W);

	ulpb_pkg::phase_t phase;
	ulpb_pkg::node_mode_t mode;
	logic [SLOT_W-1:0] slot;
	logic [RST_W-1:0] rst_cnt;
	logic eom;			// end symbol has passed, the ack slot is running.
	logic out_reg;
	logic [1:0] smp;		// [1] from drive1, [0] from drive2.
	ulpb_pkg::msg_t tx_msg;
	ulpb_pkg::msg_t rx_shift;

	logic tx_want;
	logic win;
	logic own_drv;
	logic sym;
	logic tx_next;
	logic rx_bit;
	logic rx_end;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a request already acknowledged waits for req_tx to drop.
	assign tx_want = req_tx & ~ack_tx;

	// a high input while pulling low means nobody upstream asked.
	assign win = (phase == ulpb_pkg::bus_idle) & tx_want & din;

	// the transmitter drives up to the end symbol, the receiver only its ack.
	assign own_drv = (mode == ulpb_pkg::tx) ? ~eom : ((mode == ulpb_pkg::rx) & eom);

	assign sym = smp[1] ^ smp[0];	// level change inside a slot.

	assign tx_next = (phase == ulpb_pkg::latch2) & (mode == ulpb_pkg::tx) & (slot < LAST_BIT);
	assign rx_bit = (phase == ulpb_pkg::latch2) & (mode == ulpb_pkg::rx) & ~eom & ~sym;
	assign rx_end = (phase == ulpb_pkg::latch2) & (mode == ulpb_pkg::rx) & ~eom & sym;

	always_comb
	begin
		case (phase)
			ulpb_pkg::bus_idle:
				dout = ~tx_want & din;	// arbitration pull-down.
			ulpb_pkg::bus_reset:
				dout = 1'b1;
			default:
				dout = own_drv ? out_reg : din;
		endcase
	end

	always_comb
	begin
		status.bus_idle = (phase == ulpb_pkg::bus_idle);
		case (phase)
			ulpb_pkg::bus_idle:
				status.driving = tx_want;
			ulpb_pkg::bus_reset:
				status.driving = 1'b1;
			default:
				status.driving = own_drv;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= ulpb_pkg::bus_idle;
			mode <= ulpb_pkg::idle;
			slot <= '0;
			rst_cnt <= '0;
			eom <= 1'b0;
			out_reg <= 1'b1;
			ack_tx <= 1'b0;
			req_rx <= 1'b0;
			ack_received <= 1'b0;
		end
		else
		begin
			if (ack_tx && !req_tx)
				ack_tx <= 1'b0;
			if (req_rx && ack_rx)
				req_rx <= 1'b0;

			case (phase)
				ulpb_pkg::bus_idle:
				begin
					slot <= '0;
					eom <= 1'b0;
					ack_received <= 1'b0;
					if (win)
					begin
						mode <= ulpb_pkg::tx;
						ack_tx <= 1'b1;
						out_reg <= 1'b0;	// holds the ring low for one cycle.
					end
					else
						mode <= ulpb_pkg::rx;
					phase <= ulpb_pkg::arbi_resolved;
				end

				ulpb_pkg::arbi_resolved:
				begin
					// with a winner the whole ring reads low here.
					if (din)
					begin
						mode <= ulpb_pkg::idle;
						phase <= ulpb_pkg::bus_idle;
					end
					else
					begin
						out_reg <= tx_msg[MSG_W-1];	// first address bit.
						phase <= ulpb_pkg::drive1;
					end
				end

				ulpb_pkg::drive1:
				begin
					// after ADDR_WIDTH shifts the address sits in the low bits.
					if (mode == ulpb_pkg::rx && slot == ADDR_SLOTS &&
						rx_shift[ulpb_pkg::ADDR_WIDTH-1:0] != NODE_ADDR)
						mode <= ulpb_pkg::fwd;
					phase <= ulpb_pkg::latch1;
				end

				ulpb_pkg::latch1:
				begin
					// flip mid slot to send a control symbol.
					if (own_drv && (eom || slot == END_SLOT))
						out_reg <= ~out_reg;
					phase <= ulpb_pkg::drive2;
				end

				ulpb_pkg::drive2:
					phase <= ulpb_pkg::latch2;

				ulpb_pkg::latch2:
				begin
					slot <= slot + 1'b1;
					phase <= ulpb_pkg::drive1;
					if (eom)
					begin
						if (mode == ulpb_pkg::tx)
							ack_received <= sym;
						rst_cnt <= RST_W'(RESET_CNT - 1);
						phase <= ulpb_pkg::bus_reset;
					end
					else if (mode == ulpb_pkg::tx)
					begin
						if (slot == END_SLOT)
							eom <= 1'b1;
						else if (tx_next)
							out_reg <= tx_msg[MSG_W-2];	// next bit, before the shift.
					end
					else if (sym)
					begin
						eom <= 1'b1;
						if (mode == ulpb_pkg::rx)
						begin
							req_rx <= 1'b1;
							out_reg <= 1'b1;	// ack starts high, flips in latch1.
						end
					end
				end

				ulpb_pkg::bus_reset:
				begin
					if (rst_cnt == '0)
					begin
						mode <= ulpb_pkg::idle;
						phase <= ulpb_pkg::bus_idle;
					end
					else
						rst_cnt <= rst_cnt - 1'b1;
				end

				default:
					phase <= ulpb_pkg::bus_idle;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK)
	begin
		if (win)
			tx_msg <= msg_tx;
		else if (tx_next)
			tx_msg <= {tx_msg[MSG_W-2:0], 1'b0};	// msb first.

		if (phase == ulpb_pkg::drive1 || phase == ulpb_pkg::drive2)
			smp <= {smp[0], din};

		if (rx_bit)
			rx_shift <= {rx_shift[MSG_W-2:0], smp[0]};

		// only the addressed node gets here, so msg_rx keeps the last message for it.
		if (rx_end)
			msg_rx <= rx_shift;
	end

endmodule

// File: design/ulpb_ring_ctrl.sv
`timescale 1ns/10ps

module ulpb_ring_ctrl #(
	parameter int NUM_NODES = 4
) (
	input  logic CLK,
	input  logic RESET,
	input  logic tail,
	input  ulpb_pkg::node_status_t [NUM_NODES-1:0] status,
	output logic head,
	output ulpb_pkg::count_t msg_count
);

	logic any_drv;
	ulpb_pkg::node_status_t first_q;	// node 0 status, one cycle late.
	logic msg_done;

	always_comb
	begin
		any_drv = 1'b0;
		for (int i = 0; i < NUM_NODES; i++)
			any_drv = any_drv | status[i].driving;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ring closure
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// with nobody driving the tail would only loop back on itself.
	assign head = (status[0].bus_idle || !any_drv) ? 1'b1 : tail;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// message counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// bus reset is the only non-idle phase where node 0 always drives, so an
	// aborted arbitration back to idle is not counted.
	assign msg_done = status[0].bus_idle & ~first_q.bus_idle & first_q.driving;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			first_q <= '{bus_idle: 1'b1, driving: 1'b0};
			msg_count <= '0;
		end
		else
		begin
			first_q <= status[0];
			if (msg_done)
				msg_count <= msg_count + 1'b1;
		end
	end

endmodule

// File: design/ulpb_ring_top.sv
`timescale 1ns/10ps

module ulpb_ring_top #(
	parameter int NUM_NODES = 4,
	parameter ulpb_pkg::addr_t ADDR_BASE = 8'h10,
	parameter int RESET_CNT = 2
) (
	input  logic CLK,
	input  logic RESET,
	input  ulpb_pkg::msg_t [NUM_NODES-1:0] msg_tx,
	input  logic [NUM_NODES-1:0] req_tx,
	input  logic [NUM_NODES-1:0] ack_rx,
	output logic [NUM_NODES-1:0] ack_tx,
	output ulpb_pkg::msg_t [NUM_NODES-1:0] msg_rx,
	output logic [NUM_NODES-1:0] req_rx,
	output logic [NUM_NODES-1:0] ack_received,
	output ulpb_pkg::count_t msg_count
);

	// ring[0] is the head, ring[NUM_NODES] the tail.
	logic [NUM_NODES:0] ring;
	ulpb_pkg::node_status_t [NUM_NODES-1:0] status;

	ulpb_ring_ctrl #(
		.NUM_NODES(NUM_NODES)
	) u_ctrl (
		.CLK(CLK),
		.RESET(RESET),
		.tail(ring[NUM_NODES]),
		.status(status),
		.head(ring[0]),
		.msg_count(msg_count)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// nodes, in ring order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	generate
		for (genvar i = 0; i < NUM_NODES; i++)
		begin : g_node
			ulpb_node #(
				.NODE_ADDR(ulpb_pkg::addr_t'(ADDR_BASE + i)),	// consecutive addresses.
				.RESET_CNT(RESET_CNT)
			) u_node (
				.CLK(CLK),
				.RESET(RESET),
				.din(ring[i]),
				.dout(ring[i+1]),
				.msg_tx(msg_tx[i]),
				.req_tx(req_tx[i]),
				.ack_tx(ack_tx[i]),
				.msg_rx(msg_rx[i]),
				.req_rx(req_rx[i]),
				.ack_rx(ack_rx[i]),
				.ack_received(ack_received[i]),
				.status(status[i])
			);
		end
	endgenerate

endmodule

// File: bench/ulpb_tb_ref.svh
`ifndef ULPB_TB_REF_SVH
`define ULPB_TB_REF_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// the requester closest downstream of the controller wins.
function automatic int lowest_requester(input logic [NUM_NODES-1:0] want);
	for (int i = 0; i < NUM_NODES; i++)
		if (want[i])
			return i;
	return -1;
endfunction

// a node never receives its own message, so only another node's address is acknowledged.
function automatic void predict_delivery(input int src, input ulpb_pkg::addr_t addr,
	output int rx, output logic ack);
	int idx;
	idx = int'(addr) - int'(ADDR_BASE);
	if (idx >= 0 && idx < NUM_NODES && idx != src)
		rx = idx;
	else
		rx = -1;
	ack = (rx >= 0);
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic msg_compare(input string name, input ulpb_pkg::msg_t got,
	input ulpb_pkg::msg_t exp);
	if (got !== exp)
		report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic ack_compare(input string name, input logic got, input logic exp);
	if (got !== exp)
		report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic count_compare(input string name, input ulpb_pkg::count_t got,
	input ulpb_pkg::count_t exp);
	if (got !== exp)
		report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic grant_compare(input string name, input logic [NUM_NODES-1:0] got,
	input logic [NUM_NODES-1:0] exp);
	if (got !== exp)
		report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

`endif

// File: bench/ulpb_tb.sv
`timescale 1ns/10ps

module ulpb_tb;

	localparam int NUM_NODES = 4;
	localparam ulpb_pkg::addr_t ADDR_BASE = 8'h10;
	localparam int RESET_CNT = 2;
	localparam int TIMEOUT = 400;	// cycles allowed for any single wait.

	logic CLK;
	logic RESET;
	ulpb_pkg::msg_t [NUM_NODES-1:0] msg_tx;
	logic [NUM_NODES-1:0] req_tx;
	logic [NUM_NODES-1:0] ack_rx;
	logic [NUM_NODES-1:0] ack_tx;
	ulpb_pkg::msg_t [NUM_NODES-1:0] msg_rx;
	logic [NUM_NODES-1:0] req_rx;
	logic [NUM_NODES-1:0] ack_received;
	ulpb_pkg::count_t msg_count;

	// state of the message on the ring, kept by the compare process.
	logic in_flight = 1'b0;
	int cur_src = 0;
	ulpb_pkg::msg_t cur_msg = '0;
	int exp_rx = -1;
	logic exp_ack = 1'b0;
	logic delivered = 1'b0;
	logic ack_seen = 1'b0;
	ulpb_pkg::count_t exp_count = '0;
	int checked = 0;
	int sent = 0;

	logic [NUM_NODES-1:0] ack_tx_q = '0;
	logic [NUM_NODES-1:0] req_rx_q = '0;
	logic [NUM_NODES-1:0] req_q = '0;
	ulpb_pkg::count_t count_q = '0;
	logic [NUM_NODES-1:0] ack_pending = '0;

	ulpb_ring_top #(
		.NUM_NODES(NUM_NODES),
		.ADDR_BASE(ADDR_BASE),
		.RESET_CNT(RESET_CNT)
	) dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.msg_tx(msg_tx),
		.req_tx(req_tx),
		.ack_rx(ack_rx),
		.ack_tx(ack_tx),
		.msg_rx(msg_rx),
		.req_rx(req_rx),
		.ack_received(ack_received),
		.msg_count(msg_count)
	);

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	`include "ulpb_tb_ref.svh"

	initial
	begin
		CLK = 1'b0;
		forever
			#50 CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic raise_request(input int src, input ulpb_pkg::addr_t addr,
		input ulpb_pkg::data_t data);
		ulpb_pkg::msg_t m;
		m.addr = addr;
		m.data = data;
		msg_tx[src] = m;
		req_tx[src] = 1'b1;
		sent++;
	endtask

	task automatic release_on_grant(input int src);
		int k;
		for (k = 0; k < TIMEOUT && !ack_tx[src]; k++)
			@(negedge CLK);
		if (!ack_tx[src])
			report_failure($sformatf("timeout: node %0d was never granted the bus", src));
		@(posedge CLK);
		#10;
		req_tx[src] = 1'b0;
	endtask

	task automatic wait_messages(input int n);
		int k;
		for (k = 0; k < TIMEOUT && checked < n; k++)
			@(posedge CLK);
		if (checked < n)
			report_failure($sformatf("timeout: message %0d never finished on the ring", n));
	endtask

	task automatic send_msg(input int src, input ulpb_pkg::addr_t addr,
		input ulpb_pkg::data_t data);
		@(posedge CLK);
		#10;
		raise_request(src, addr, data);
		release_on_grant(src);
		wait_messages(sent);
	endtask

	// the host always takes a received message in the cycle after req_rx rises.
	initial
	begin
		ack_rx = '0;
		forever
		begin
			@(posedge CLK);
			#10;
			ack_rx = ack_pending;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare process
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge CLK)
	begin : compare
		logic [NUM_NODES-1:0] grant_rise;
		logic [NUM_NODES-1:0] rx_rise;
		logic [NUM_NODES-1:0] exp_grant;
		int w;
		if (RESET)
		begin
			// the counter step closes the current message.
			if (msg_count != count_q)
			begin
				if (!in_flight)
					report_failure("msg_count moved although no node had been granted");
				exp_count = exp_count + 1'b1;
				count_compare("msg_count", msg_count, exp_count);
				if (exp_rx >= 0 && !delivered)
					report_failure($sformatf("node %0d never raised req_rx", exp_rx));
				ack_compare($sformatf("ack_received[%0d]", cur_src), ack_seen, exp_ack);
				in_flight = 1'b0;
				checked++;
			end

			grant_rise = ack_tx & ~ack_tx_q;
			if (grant_rise != '0)
			begin
				w = lowest_requester(req_q & ~ack_tx_q);
				if (w < 0)
					report_failure("ack_tx rose while no request was pending");
				else
				begin
					exp_grant = '0;
					exp_grant[w] = 1'b1;
					grant_compare("ack_tx", grant_rise, exp_grant);
					if (in_flight)
						report_failure("a node was granted before the last message ended");
					cur_src = w;
					cur_msg = msg_tx[w];
					predict_delivery(w, cur_msg.addr, exp_rx, exp_ack);
					delivered = 1'b0;
					ack_seen = 1'b0;
					in_flight = 1'b1;
				end
			end

			rx_rise = req_rx & ~req_rx_q;
			for (int i = 0; i < NUM_NODES; i++)
			begin
				if (rx_rise[i])
				begin
					if (!in_flight || i != exp_rx || delivered)
						report_failure($sformatf("node %0d raised req_rx unexpectedly", i));
					msg_compare($sformatf("msg_rx[%0d]", i), msg_rx[i], cur_msg);
					delivered = 1'b1;
				end
			end

			if (in_flight && ack_received[cur_src])
				ack_seen = 1'b1;	// high only for a few cycles around bus reset.
		end
		ack_tx_q = ack_tx;
		req_rx_q = req_rx;
		req_q = req_tx;
		count_q = msg_count;
		ack_pending = req_rx;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin : stimulus
		int src;
		int pick;
		ulpb_pkg::addr_t addr;
		void'($urandom(5));
		RESET = 1'b0;
		req_tx = '0;
		msg_tx = '0;
		repeat (2) @(posedge CLK);
		#10;
		RESET = 1'b1;

		send_msg(0, ulpb_pkg::addr_t'(ADDR_BASE + 2), 32'hcafe_0102);
		send_msg(1, 8'h80, 32'h0bad_add0);	// no node has this address.

		// nodes 1 and 3 ask in the same cycle, node 1 sits nearer the head.
		@(posedge CLK);
		#10;
		raise_request(1, ulpb_pkg::addr_t'(ADDR_BASE + 2), 32'h1111_2222);
		raise_request(3, ulpb_pkg::addr_t'(ADDR_BASE + 1), 32'h3333_4444);
		release_on_grant(1);
		release_on_grant(3);
		wait_messages(sent);

		send_msg(3, ADDR_BASE, 32'h5a5a_3030);	// wraps through the controller.

		for (int n = 0; n < 40; n++)
		begin
			src = $urandom % NUM_NODES;
			pick = $urandom % (NUM_NODES + 2);
			if (pick < NUM_NODES)
				addr = ulpb_pkg::addr_t'(ADDR_BASE + pick);
			else
				addr = ulpb_pkg::addr_t'($urandom);
			send_msg(src, addr, ulpb_pkg::data_t'($urandom));
		end

		@(negedge CLK);
		count_compare("msg_count", msg_count, ulpb_pkg::count_t'(sent));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: project.f
+incdir+bench
design/ulpb_pkg.sv
design/ulpb_node.sv
design/ulpb_ring_ctrl.sv
design/ulpb_ring_top.sv
bench/ulpb_tb.sv

// File: Makefile
# Verilator build and run of the ring bus testbench.

TOP = ulpb_tb
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
